// File: hw/core_pkg.sv
package core_pkg;

  // Datapath and address widths
  localparam int WORD_WIDTH = 16;
  localparam int OPCODE_WIDTH = 8;
  localparam int INSTR_WIDTH = WORD_WIDTH + OPCODE_WIDTH;
  localparam int PROG_ADDR_WIDTH = 8;
  localparam int MAIN_ADDR_WIDTH = 8;

  // Both stacks are rings, so the depths must be powers of two
  localparam int DSTACK_DEPTH = 8;
  localparam int CSTACK_DEPTH = 4;
  localparam int DSTACK_PTR_WIDTH = $clog2(DSTACK_DEPTH);
  localparam int CSTACK_PTR_WIDTH = $clog2(CSTACK_DEPTH);

  localparam int ALU_OP_WIDTH = 4;
  localparam int STK_OP_WIDTH = 3;
  localparam int FLOW_OP_WIDTH = 3;

  // Upper nibble of the opcode selects the instruction class
  localparam logic [3:0] CLASS_MISC = 4'h0;
  localparam logic [3:0] CLASS_ALU = 4'h1;
  localparam logic [3:0] CLASS_FLOW = 4'h2;

  localparam logic [OPCODE_WIDTH-1:0] OP_NOP = {CLASS_MISC, 4'h0};
  localparam logic [OPCODE_WIDTH-1:0] OP_HALT = {CLASS_MISC, 4'h1};
  localparam logic [OPCODE_WIDTH-1:0] OP_PUSHI = {CLASS_MISC, 4'h2};
  localparam logic [OPCODE_WIDTH-1:0] OP_DROP = {CLASS_MISC, 4'h3};
  localparam logic [OPCODE_WIDTH-1:0] OP_DUP = {CLASS_MISC, 4'h4};
  localparam logic [OPCODE_WIDTH-1:0] OP_SWAP = {CLASS_MISC, 4'h5};
  localparam logic [OPCODE_WIDTH-1:0] OP_STORE = {CLASS_MISC, 4'h6};

  localparam logic [OPCODE_WIDTH-1:0] OP_JMPI = {CLASS_FLOW, 4'h0};
  localparam logic [OPCODE_WIDTH-1:0] OP_BZI = {CLASS_FLOW, 4'h1};
  localparam logic [OPCODE_WIDTH-1:0] OP_CALLI = {CLASS_FLOW, 4'h2};
  localparam logic [OPCODE_WIDTH-1:0] OP_RET = {CLASS_FLOW, 4'h3};

  // ALU operations, carried in the low nibble of a class 1 opcode
  localparam logic [ALU_OP_WIDTH-1:0] ALU_ADD = 4'h0;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_ADDC = 4'h1;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SUB = 4'h2;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_AND = 4'h3;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OR = 4'h4;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_XOR = 4'h5;

  localparam logic [STK_OP_WIDTH-1:0] STK_NONE = 3'd0;
  localparam logic [STK_OP_WIDTH-1:0] STK_PUSH_IMM = 3'd1;
  localparam logic [STK_OP_WIDTH-1:0] STK_DROP = 3'd2;
  localparam logic [STK_OP_WIDTH-1:0] STK_DUP = 3'd3;
  localparam logic [STK_OP_WIDTH-1:0] STK_SWAP = 3'd4;
  localparam logic [STK_OP_WIDTH-1:0] STK_ALU = 3'd5;
  localparam logic [STK_OP_WIDTH-1:0] STK_STORE = 3'd6;

  localparam logic [FLOW_OP_WIDTH-1:0] FLOW_SEQ = 3'd0;
  localparam logic [FLOW_OP_WIDTH-1:0] FLOW_HALT = 3'd1;
  localparam logic [FLOW_OP_WIDTH-1:0] FLOW_JUMP = 3'd2;
  localparam logic [FLOW_OP_WIDTH-1:0] FLOW_BZ = 3'd3;
  localparam logic [FLOW_OP_WIDTH-1:0] FLOW_CALL = 3'd4;
  localparam logic [FLOW_OP_WIDTH-1:0] FLOW_RET = 3'd5;

  // The decoder matches whole opcodes and also splits ALU opcodes by nibble
  typedef union packed {
    logic [OPCODE_WIDTH-1:0] whole;
    struct packed {
      logic [3:0] op_class;
      logic [ALU_OP_WIDTH-1:0] alu_op;
    } split;
  } opcode_u;

endpackage

// File: hw/decode_if.sv
interface decode_if import core_pkg::*; (
  input logic clk,
  input logic rst_n
);

  logic [STK_OP_WIDTH-1:0] stack_op;
  logic [ALU_OP_WIDTH-1:0] alu_op;
  logic [WORD_WIDTH-1:0] imm;
  logic [FLOW_OP_WIDTH-1:0] flow_op;

  // Clock and reset reach the decoder only for its opcode check
  modport decoder (
    input clk,
    input rst_n,
    output stack_op,
    output alu_op,
    output imm,
    output flow_op
  );

  modport stack (
    input stack_op,
    input alu_op,
    input imm
  );

  modport sequencer (
    input flow_op,
    input imm
  );

endinterface

// File: hw/fetch_decode.sv
module fetch_decode import core_pkg::*; (
  input logic [INSTR_WIDTH-1:0] programmem_read_value,
  decode_if.decoder dec
);

  opcode_u opcode;

  // The immediate sits above the opcode byte in the fetched word
  assign opcode.whole = programmem_read_value[OPCODE_WIDTH-1:0];
  assign dec.imm = programmem_read_value[INSTR_WIDTH-1:OPCODE_WIDTH];
  assign dec.alu_op = opcode.split.alu_op;

  always_comb begin
    dec.stack_op = STK_NONE;
    dec.flow_op = FLOW_SEQ;
    if (opcode.split.op_class == CLASS_ALU) begin
      // Low nibbles past XOR are undefined and fall through as NOP
      if (opcode.split.alu_op <= ALU_XOR) begin
        dec.stack_op = STK_ALU;
      end
    end else begin
      case (opcode.whole)
        OP_HALT: begin
          dec.flow_op = FLOW_HALT;
        end
        OP_PUSHI: begin
          dec.stack_op = STK_PUSH_IMM;
        end
        OP_DROP: begin
          dec.stack_op = STK_DROP;
        end
        OP_DUP: begin
          dec.stack_op = STK_DUP;
        end
        OP_SWAP: begin
          dec.stack_op = STK_SWAP;
        end
        OP_STORE: begin
          dec.stack_op = STK_STORE;
        end
        OP_JMPI: begin
          dec.flow_op = FLOW_JUMP;
        end
        OP_BZI: begin
          // The tested top leaves the stack whichever way the branch goes
          dec.stack_op = STK_DROP;
          dec.flow_op = FLOW_BZ;
        end
        OP_CALLI: begin
          dec.flow_op = FLOW_CALL;
        end
        OP_RET: begin
          dec.flow_op = FLOW_RET;
        end
        default: begin
        end
      endcase
    end
  end

  // Program memory must deliver a defined opcode once the core runs
  opcode_known: assert property (
    @(posedge dec.clk) disable iff (!dec.rst_n) !$isunknown(opcode.whole)
  ) else $error("fetch_decode: unknown opcode fetched");

endmodule

// File: hw/alu.sv
module alu import core_pkg::*; (
  input logic [WORD_WIDTH-1:0] a,
  input logic [WORD_WIDTH-1:0] b,
  input logic carry_in,
  input logic [ALU_OP_WIDTH-1:0] alu_op,
  output logic [WORD_WIDTH-1:0] result,
  output logic carry_out,
  output logic carry_write
);

  logic [WORD_WIDTH:0] sum;

  always_comb begin
    sum = '0;
    result = '0;
    carry_out = carry_in;
    carry_write = 1'b0;
    case (alu_op)
      ALU_ADD: begin
        sum = {1'b0, a} + {1'b0, b};
        carry_write = 1'b1;
      end
      ALU_ADDC: begin
        sum = {1'b0, a} + {1'b0, b} + {{WORD_WIDTH{1'b0}}, carry_in};
        carry_write = 1'b1;
      end
      ALU_SUB: begin
        // Two's complement add, so the top bit is set when no borrow occurs
        sum = {1'b0, a} + {1'b0, ~b} + {{WORD_WIDTH{1'b0}}, 1'b1};
        carry_write = 1'b1;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_XOR: begin
        result = a ^ b;
      end
      default: begin
      end
    endcase
    if (carry_write) begin
      result = sum[WORD_WIDTH-1:0];
      carry_out = sum[WORD_WIDTH];
    end
  end

endmodule

// File: hw/data_stack.sv
module data_stack import core_pkg::*; (
  input logic clk,
  input logic rst_n,
  decode_if.stack ctl,
  output logic top_zero,
  output logic mainmem_we,
  output logic [MAIN_ADDR_WIDTH-1:0] mainmem_addr,
  output logic [WORD_WIDTH-1:0] mainmem_value
);

  logic [WORD_WIDTH-1:0] ring [DSTACK_DEPTH];
  // Points at the newest entry, and wraps around the ring without any check
  logic [DSTACK_PTR_WIDTH-1:0] ptr;
  logic [DSTACK_PTR_WIDTH-1:0] ptr_up;
  logic [DSTACK_PTR_WIDTH-1:0] ptr_dn;
  logic [DSTACK_PTR_WIDTH-1:0] ptr_dn2;
  logic carry;

  logic [WORD_WIDTH-1:0] top;
  logic [WORD_WIDTH-1:0] second;
  logic [WORD_WIDTH-1:0] alu_result;
  logic alu_carry_out;
  logic alu_carry_write;

  assign ptr_up = ptr + 1'b1;
  assign ptr_dn = ptr - 1'b1;
  assign ptr_dn2 = ptr_dn - 1'b1;

  assign top = ring[ptr];
  assign second = ring[ptr_dn];
  assign top_zero = (top == '0);

  // Second is the left operand, so SUB gives second minus top
  alu u_alu (
    .a(second),
    .b(top),
    .carry_in(carry),
    .alu_op(ctl.alu_op),
    .result(alu_result),
    .carry_out(alu_carry_out),
    .carry_write(alu_carry_write)
  );

  // The store strobe belongs to the current instruction and is silent in reset
  assign mainmem_we = rst_n && (ctl.stack_op == STK_STORE);
  assign mainmem_addr = top[MAIN_ADDR_WIDTH-1:0];
  assign mainmem_value = second;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DSTACK_DEPTH; i++) begin
        ring[i] <= '0;
      end
      ptr <= '0;
      carry <= 1'b0;
    end else begin
      case (ctl.stack_op)
        STK_PUSH_IMM: begin
          ring[ptr_up] <= ctl.imm;
          ptr <= ptr_up;
        end
        STK_DUP: begin
          ring[ptr_up] <= top;
          ptr <= ptr_up;
        end
        STK_DROP: begin
          ptr <= ptr_dn;
        end
        STK_SWAP: begin
          ring[ptr] <= second;
          ring[ptr_dn] <= top;
        end
        STK_ALU: begin
          ring[ptr_dn] <= alu_result;
          ptr <= ptr_dn;
        end
        STK_STORE: begin
          ptr <= ptr_dn2;
        end
        default: begin
        end
      endcase
      if (ctl.stack_op == STK_ALU && alu_carry_write) begin
        carry <= alu_carry_out;
      end
    end
  end

  stack_op_legal: assert property (
    @(posedge clk) disable iff (!rst_n) ctl.stack_op <= STK_STORE
  ) else $error("data_stack: undefined stack_op %0d", ctl.stack_op);

  // The decoder only issues ALU work for the six defined operations
  alu_op_legal: assert property (
    @(posedge clk) disable iff (!rst_n) (ctl.stack_op == STK_ALU) |-> (ctl.alu_op <= ALU_XOR)
  ) else $error("data_stack: ALU work with undefined alu_op %0d", ctl.alu_op);

endmodule

// File: hw/pc_control.sv
module pc_control import core_pkg::*; (
  input logic clk,
  input logic rst_n,
  decode_if.sequencer ctl,
  input logic top_zero,
  output logic [PROG_ADDR_WIDTH-1:0] programmem_addr
);

  logic [PROG_ADDR_WIDTH-1:0] pc;
  logic [PROG_ADDR_WIDTH-1:0] pc_inc;
  logic [PROG_ADDR_WIDTH-1:0] pc_next;
  logic [PROG_ADDR_WIDTH-1:0] target;

  // Return addresses are kept with the pointer on the newest entry
  logic [PROG_ADDR_WIDTH-1:0] cring [CSTACK_DEPTH];
  logic [CSTACK_PTR_WIDTH-1:0] cptr;
  logic [CSTACK_PTR_WIDTH-1:0] cptr_up;

  assign pc_inc = pc + 1'b1;
  assign target = ctl.imm[PROG_ADDR_WIDTH-1:0];
  assign cptr_up = cptr + 1'b1;

  always_comb begin
    case (ctl.flow_op)
      FLOW_HALT: pc_next = pc;
      FLOW_JUMP: pc_next = target;
      FLOW_BZ: pc_next = top_zero ? target : pc_inc;
      FLOW_CALL: pc_next = target;
      FLOW_RET: pc_next = cring[cptr];
      default: pc_next = pc_inc;
    endcase
  end

  // Memory fetches from 0 throughout reset so word 0 is ready on release
  assign programmem_addr = rst_n ? pc_next : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
      for (int i = 0; i < CSTACK_DEPTH; i++) begin
        cring[i] <= '0;
      end
      cptr <= '0;
    end else begin
      pc <= pc_next;
      if (ctl.flow_op == FLOW_CALL) begin
        cring[cptr_up] <= pc_inc;
        cptr <= cptr_up;
      end else if (ctl.flow_op == FLOW_RET) begin
        cptr <= cptr - 1'b1;
      end
    end
  end

  flow_op_legal: assert property (
    @(posedge clk) disable iff (!rst_n) ctl.flow_op <= FLOW_RET
  ) else $error("pc_control: undefined flow_op %0d", ctl.flow_op);

endmodule

// File: hw/core_top.sv
module core_top import core_pkg::*; (
  input logic clk,
  input logic rst_n,
  output logic [PROG_ADDR_WIDTH-1:0] programmem_addr,
  input logic [INSTR_WIDTH-1:0] programmem_read_value,
  output logic mainmem_we,
  output logic [MAIN_ADDR_WIDTH-1:0] mainmem_addr,
  output logic [WORD_WIDTH-1:0] mainmem_value
);

  logic top_zero;

  decode_if dec_bus (
    .clk(clk),
    .rst_n(rst_n)
  );

  fetch_decode u_fetch_decode (
    .programmem_read_value(programmem_read_value),
    .dec(dec_bus.decoder)
  );

  data_stack u_data_stack (
    .clk(clk),
    .rst_n(rst_n),
    .ctl(dec_bus.stack),
    .top_zero(top_zero),
    .mainmem_we(mainmem_we),
    .mainmem_addr(mainmem_addr),
    .mainmem_value(mainmem_value)
  );

  // BZI tests the top before the same edge pops it
  pc_control u_pc_control (
    .clk(clk),
    .rst_n(rst_n),
    .ctl(dec_bus.sequencer),
    .top_zero(top_zero),
    .programmem_addr(programmem_addr)
  );

endmodule

// File: bench/core_model_pkg.sv
package core_model_pkg;
  timeunit 1ns;
  timeprecision 1ps;

  import core_pkg::*;

  // Architectural state, with each stack index on its newest entry
  logic [WORD_WIDTH-1:0] dstack [DSTACK_DEPTH];
  int dtop;
  logic carry;
  logic [PROG_ADDR_WIDTH-1:0] pc;
  logic [PROG_ADDR_WIDTH-1:0] cstack [CSTACK_DEPTH];
  int ctop;

  function automatic int ring_next(input int idx, input int depth);
    return (idx + 1) % depth;
  endfunction

  function automatic int ring_prev(input int idx, input int depth);
    return (idx + depth - 1) % depth;
  endfunction

  function automatic void clear_state();
    foreach (dstack[i]) begin
      dstack[i] = '0;
    end
    foreach (cstack[i]) begin
      cstack[i] = '0;
    end
    dtop = 0;
    ctop = 0;
    carry = 1'b0;
    pc = '0;
  endfunction

  function automatic logic [PROG_ADDR_WIDTH-1:0] current_pc();
    return pc;
  endfunction

  // Result of second op top, updating the carry where the operation defines one
  function automatic logic [WORD_WIDTH-1:0] alu_result(
    input logic [ALU_OP_WIDTH-1:0] fn,
    input logic [WORD_WIDTH-1:0] lhs,
    input logic [WORD_WIDTH-1:0] rhs
  );
    logic [31:0] wide;
    wide = '0;
    case (fn)
      ALU_ADD: begin
        wide = 32'(lhs) + 32'(rhs);
        carry = wide[WORD_WIDTH];
      end
      ALU_ADDC: begin
        wide = 32'(lhs) + 32'(rhs) + 32'(carry);
        carry = wide[WORD_WIDTH];
      end
      ALU_SUB: begin
        // No borrow exactly when the left operand is at least the right one
        carry = (lhs >= rhs);
        wide = 32'(lhs - rhs);
      end
      ALU_AND: wide = 32'(lhs & rhs);
      ALU_OR: wide = 32'(lhs | rhs);
      ALU_XOR: wide = 32'(lhs ^ rhs);
      default: wide = '0;
    endcase
    return wide[WORD_WIDTH-1:0];
  endfunction

  // Runs one instruction and reports the fetch address and store it implies
  function automatic void execute(
    input logic [INSTR_WIDTH-1:0] word,
    output logic [PROG_ADDR_WIDTH-1:0] next_pc,
    output logic store_we,
    output logic [MAIN_ADDR_WIDTH-1:0] store_addr,
    output logic [WORD_WIDTH-1:0] store_value
  );
    logic [OPCODE_WIDTH-1:0] op;
    logic [WORD_WIDTH-1:0] imm;
    logic [WORD_WIDTH-1:0] top;
    logic [WORD_WIDTH-1:0] second;
    int below;
    op = word[OPCODE_WIDTH-1:0];
    imm = word[INSTR_WIDTH-1:OPCODE_WIDTH];
    below = ring_prev(dtop, DSTACK_DEPTH);
    top = dstack[dtop];
    second = dstack[below];
    next_pc = pc + 1'b1;
    store_we = 1'b0;
    store_addr = '0;
    store_value = '0;
    if (op[7:4] == CLASS_ALU) begin
      if (op[3:0] < 4'd6) begin
        dstack[below] = alu_result(op[3:0], second, top);
        dtop = below;
      end
    end else begin
      case (op)
        OP_PUSHI: begin
          dtop = ring_next(dtop, DSTACK_DEPTH);
          dstack[dtop] = imm;
        end
        OP_DUP: begin
          dtop = ring_next(dtop, DSTACK_DEPTH);
          dstack[dtop] = top;
        end
        OP_DROP: dtop = below;
        OP_SWAP: begin
          dstack[dtop] = second;
          dstack[below] = top;
        end
        OP_STORE: begin
          store_we = 1'b1;
          store_addr = top[MAIN_ADDR_WIDTH-1:0];
          store_value = second;
          dtop = ring_prev(below, DSTACK_DEPTH);
        end
        OP_HALT: next_pc = pc;
        OP_JMPI: next_pc = imm[PROG_ADDR_WIDTH-1:0];
        OP_BZI: begin
          if (top == '0) begin
            next_pc = imm[PROG_ADDR_WIDTH-1:0];
          end
          dtop = below;
        end
        OP_CALLI: begin
          ctop = ring_next(ctop, CSTACK_DEPTH);
          cstack[ctop] = pc + 1'b1;
          next_pc = imm[PROG_ADDR_WIDTH-1:0];
        end
        OP_RET: begin
          next_pc = cstack[ctop];
          ctop = ring_prev(ctop, CSTACK_DEPTH);
        end
        default: begin
        end
      endcase
    end
    pc = next_pc;
  endfunction

endpackage

// File: bench/tb_core.sv
module tb_core
  import core_pkg::*;
  import core_model_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 4;
  localparam int TESTS = 12;
  localparam int RESET_CYCLES = 5;
  localparam int RUN_CYCLES = 150;
  localparam int PROG_WORDS = 64;
  localparam int SEED = 8151;
  localparam int WATCHDOG_NS = TESTS * (RESET_CYCLES + RUN_CYCLES) * CLK_PERIOD + 10000;

  logic clk;
  logic rst_n;
  logic [PROG_ADDR_WIDTH-1:0] programmem_addr;
  logic [INSTR_WIDTH-1:0] programmem_read_value;
  logic mainmem_we;
  logic [MAIN_ADDR_WIDTH-1:0] mainmem_addr;
  logic [WORD_WIDTH-1:0] mainmem_value;

  logic [INSTR_WIDTH-1:0] program_mem [PROG_WORDS];
  int errors;
  int checks;

  core_top UUT (
    .clk(clk),
    .rst_n(rst_n),
    .programmem_addr(programmem_addr),
    .programmem_read_value(programmem_read_value),
    .mainmem_we(mainmem_we),
    .mainmem_addr(mainmem_addr),
    .mainmem_value(mainmem_value)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Addresses above 63 alias into the 64-word program memory
  function automatic logic [INSTR_WIDTH-1:0] read_program(input logic [PROG_ADDR_WIDTH-1:0] addr);
    return program_mem[int'(addr) % PROG_WORDS];
  endfunction

  // Pushes and ALU work dominate so that the stack stays busy
  task automatic fill_program();
    int pick;
    logic [OPCODE_WIDTH-1:0] op;
    logic [WORD_WIDTH-1:0] imm;
    for (int a = 0; a < PROG_WORDS; a++) begin
      pick = int'($urandom % 32);
      case (pick) inside
        [0:8]: op = OP_PUSHI;
        [9:15]: op = {CLASS_ALU, 4'($urandom % 8)};
        [16:17]: op = OP_DUP;
        18: op = OP_DROP;
        [19:20]: op = OP_SWAP;
        [21:23]: op = OP_STORE;
        [24:25]: op = OP_BZI;
        26: op = OP_JMPI;
        27: op = OP_CALLI;
        28: op = OP_RET;
        29: op = OP_NOP;
        30: op = OP_HALT;
        default: op = OPCODE_WIDTH'($urandom);
      endcase
      if (op inside {OP_JMPI, OP_BZI, OP_CALLI}) begin
        imm = WORD_WIDTH'($urandom % PROG_WORDS);
      end else if (op == OP_PUSHI && $urandom % 4 == 0) begin
        // Zero pushes give BZI a taken branch now and then
        imm = '0;
      end else begin
        imm = WORD_WIDTH'($urandom);
      end
      program_mem[a] = {imm, op};
    end
  endtask

  task automatic check_outputs(
    input logic [PROG_ADDR_WIDTH-1:0] exp_addr,
    input logic exp_we,
    input logic [MAIN_ADDR_WIDTH-1:0] exp_maddr,
    input logic [WORD_WIDTH-1:0] exp_mval
  );
    checks++;
    assert (programmem_addr === exp_addr) else begin
      errors++;
      $display("Fail at %0t ns: programmem_addr expected %h, got %h",
               $time, exp_addr, programmem_addr);
    end
    assert (mainmem_we === exp_we) else begin
      errors++;
      $display("Fail at %0t ns: mainmem_we expected %b, got %b", $time, exp_we, mainmem_we);
    end
    if (exp_we) begin
      assert (mainmem_addr === exp_maddr) else begin
        errors++;
        $display("Fail at %0t ns: mainmem_addr expected %h, got %h",
                 $time, exp_maddr, mainmem_addr);
      end
      assert (mainmem_value === exp_mval) else begin
        errors++;
        $display("Fail at %0t ns: mainmem_value expected %h, got %h",
                 $time, exp_mval, mainmem_value);
      end
    end
  endtask

  // Outputs are checked at the falling edge, and the fetched word lands 1 ns after the rise
  task automatic run_program();
    logic [PROG_ADDR_WIDTH-1:0] fetch_addr;
    logic [PROG_ADDR_WIDTH-1:0] exp_addr;
    logic exp_we;
    logic [MAIN_ADDR_WIDTH-1:0] exp_maddr;
    logic [WORD_WIDTH-1:0] exp_mval;
    fill_program();
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    clear_state();
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_outputs('0, 1'b0, '0, '0);
      fetch_addr = programmem_addr;
      @(posedge clk);
      #1;
      programmem_read_value = read_program(fetch_addr);
    end
    rst_n = 1'b1;
    repeat (RUN_CYCLES) begin
      @(negedge clk);
      execute(read_program(current_pc()), exp_addr, exp_we, exp_maddr, exp_mval);
      check_outputs(exp_addr, exp_we, exp_maddr, exp_mval);
      fetch_addr = programmem_addr;
      @(posedge clk);
      #1;
      programmem_read_value = read_program(fetch_addr);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    programmem_read_value = '0;
    errors = 0;
    checks = 0;
    void'($urandom(SEED));
    for (int t = 0; t < TESTS; t++) begin
      run_program();
    end
    $display("Ran %0d programs: %0d errors in %0d checks", TESTS, errors, checks);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all programs had run");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: compile.f
hw/core_pkg.sv
hw/decode_if.sv
hw/fetch_decode.sv
hw/alu.sv
hw/data_stack.sv
hw/pc_control.sv
hw/core_top.sv
bench/core_model_pkg.sv
bench/tb_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_core -f compile.f -o sim_tb_core
sim_out=$(./obj_dir/sim_tb_core)
echo "$sim_out"
if echo "$sim_out" | grep -qx "NO ERRORS"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
